/* all.f */
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_age.sv
icache_ctrl.sv
icache_top.sv
tb_icache_checker.sv
tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_icache -o tb_icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_icache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

/* tb_icache.sv */
//********************
// testbench top for the two-way instruction cache
// drives seeded random core requests, models the memory
// with random wait states and bounds the run with a watchdog
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int RANDOM_REQS  = 200;
    localparam int TOTAL_REQS   = 8 + 16 + 16 + 49 + RANDOM_REQS;
    // miss with 4 wait states plus the largest gap
    localparam int WORST_CYCLES = 16;

    logic              clk = 1'b0;
    logic              rst;
    logic              cpu_cyc;
    logic              cpu_stb;
    logic [ADDR_W-1:0] cpu_adr;
    logic              cpu_ack;
    logic [WORD_W-1:0] cpu_dat;
    logic              mem_cyc;
    logic              mem_stb;
    logic [ADDR_W-1:0] mem_adr;
    logic              mem_ack = 1'b0;
    logic [LINE_W-1:0] mem_dat = '0;
    logic [LINE_W-1:0] mem_line;
    logic [2:0]        test_id;
    logic              test_done;
    logic              refill_busy = 1'b0;
    int                wait_left = 0;
    int                errors;
    int                requests;

    always #10 clk = ~clk;

    icache_top u_dut (
        .clk(clk), .rst(rst),
        .i_cpu_cyc(cpu_cyc), .i_cpu_stb(cpu_stb), .i_cpu_adr(cpu_adr),
        .o_cpu_ack(cpu_ack), .o_cpu_dat(cpu_dat),
        .o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb), .o_mem_adr(mem_adr),
        .i_mem_ack(mem_ack), .i_mem_dat(mem_dat)
    );

    tb_icache_checker u_chk (
        .clk(clk), .rst(rst),
        .i_cpu_cyc(cpu_cyc), .i_cpu_stb(cpu_stb), .i_cpu_adr(cpu_adr),
        .i_cpu_ack(cpu_ack), .i_cpu_dat(cpu_dat),
        .i_mem_cyc(mem_cyc), .i_mem_stb(mem_stb), .i_mem_adr(mem_adr),
        .i_test_id(test_id), .i_test_done(test_done),
        .o_mem_line(mem_line), .o_errors(errors), .o_requests(requests)
    );

    // memory slave, 0 to 4 wait states per refill
    always @(posedge clk) begin
        #2;
        if (mem_ack) begin
            mem_ack = 1'b0;
            refill_busy = 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!refill_busy) begin
                refill_busy = 1'b1;
                wait_left = $urandom % 5;
            end
            if (wait_left == 0) begin
                mem_ack = 1'b1;
                mem_dat = mem_line;
            end else begin
                wait_left--;
            end
        end
    end

    function automatic int rand_gap();
        return $urandom % 4;
    endfunction

    function automatic logic [ADDR_W-1:0] set_adr(input logic [TAG_W-1:0] tag,
                                                  input logic [INDEX_W-1:0] set);
        return {tag, set, 1'($urandom), 2'b00};
    endfunction

    // entered and left 2 ns after a rising edge
    task automatic request(input logic [ADDR_W-1:0] adr, input int gap);
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_adr = adr;
        do begin
            @(negedge clk);
        end while (!cpu_ack);
        @(posedge clk);
        #2;
        if (gap > 0) begin
            cpu_cyc = 1'b0;
            cpu_stb = 1'b0;
            repeat (gap) @(posedge clk);
            #2;
        end
    endtask

    task automatic end_test();
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        test_done = 1'b1;
        @(posedge clk);
        #2;
        test_done = 1'b0;
    endtask

    initial begin
        logic [TAG_W-1:0]   tags [3];
        logic [INDEX_W-1:0] set;
        logic [ADDR_W-1:0]  a;
        int                 k;
        void'($urandom(32'h52b1c074));
        rst = 1'b0;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_adr = '0;
        test_id = 3'd0;
        test_done = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;

        // quiet after reset, then first touches of new lines
        repeat (10) @(posedge clk);
        #2;
        for (int i = 0; i < 8; i++) begin
            request($urandom & 32'hffff_fffc, rand_gap());
        end
        end_test();

        test_id = 3'd1;
        for (int i = 0; i < 8; i++) begin
            a = $urandom & 32'h0000_fff8;
            request(a, rand_gap());
            request(a | 32'h4, rand_gap());
        end
        end_test();

        test_id = 3'd2;
        for (int i = 0; i < 8; i++) begin
            a = $urandom & 32'h0003_fffc;
            request(a, rand_gap());
            request(a | 32'h4, rand_gap());
        end
        end_test();

        // three tags fight over two ways of one set
        test_id = 3'd3;
        set = 6'($urandom);
        tags[0] = 23'($urandom);
        tags[1] = tags[0] ^ 23'd1;
        tags[2] = tags[0] ^ 23'd2;
        for (int i = 0; i < 16; i++) begin
            k = $urandom % 3;
            request(set_adr(tags[k], set), rand_gap());
        end
        // set holds tags 1 and 0, the way of tag 1 saturates
        request(set_adr(tags[1], set), rand_gap());
        for (int i = 0; i < 8; i++) begin
            request(set_adr(tags[0], set), rand_gap());
        end
        // both ways saturate, so the tag 2 miss is a tie
        for (int i = 0; i < 8; i++) begin
            request(set_adr(tags[0], set + 6'd1), rand_gap());
        end
        request(set_adr(tags[2], set), rand_gap());
        for (int i = 0; i < 15; i++) begin
            k = $urandom % 3;
            request(set_adr(tags[k], set), rand_gap());
        end
        end_test();

        test_id = 3'd4;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            request($urandom & 32'h0000_0ffc, rand_gap());
        end
        end_test();

        repeat (4) @(posedge clk);
        $display("5 tests, %0d requests, %0d errors", requests, errors);
        if (errors == 0 && requests == TOTAL_REQS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #((TOTAL_REQS * WORST_CYCLES + 100) * 20);
        $display("watchdog expired with %0d of %0d requests done", requests, TOTAL_REQS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_icache_checker.sv */
//********************
// testbench checker for the instruction cache
// keeps a reference model of tags, valid bits and ages,
// compares every core response and refill, reports per test
//********************
`timescale 1ns/1ps
`default_nettype none

module tb_icache_checker (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          i_cpu_cyc,
    input  wire logic                          i_cpu_stb,
    input  wire logic [icache_pkg::ADDR_W-1:0] i_cpu_adr,
    input  wire logic                          i_cpu_ack,
    input  wire logic [icache_pkg::WORD_W-1:0] i_cpu_dat,
    input  wire logic                          i_mem_cyc,
    input  wire logic                          i_mem_stb,
    input  wire logic [icache_pkg::ADDR_W-1:0] i_mem_adr,
    input  wire logic [2:0]                    i_test_id,
    input  wire logic                          i_test_done,
    output logic      [icache_pkg::LINE_W-1:0] o_mem_line,
    output int                                 o_errors,
    output int                                 o_requests
);
    import icache_pkg::*;

    logic [TAG_W-1:0]  m_tag [2][SETS];
    logic              m_valid [2][SETS];
    int                m_age [2][SETS];
    logic              busy;
    logic              exp_miss;
    logic              mem_cyc_q;
    logic [ADDR_W-1:0] req_adr;
    logic [WORD_W-1:0] exp_dat;
    int                cycles;
    int                refills;
    int                test_reqs;
    int                test_errs;

    // memory contents, a fixed mix of the line address
    function automatic logic [LINE_W-1:0] line_for(input logic [ADDR_W-1:0] a);
        return {a * 32'h9e3779b1 ^ 32'hc2b2ae35, {a[15:0], a[31:16]} ^ a ^ 32'h27d4eb2f};
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_first_fill";
            3'd1:    return "line_halves";
            3'd2:    return "repeat_hit";
            3'd3:    return "same_set_ages";
            default: return "random_region";
        endcase
    endfunction

    assign o_mem_line = line_for(i_mem_adr);

    task automatic report(input string msg);
        $display("%s", msg);
        test_errs++;
        o_errors++;
    endtask

    // age all sets, then look up and fill like the cache should
    task automatic predict(input logic [ADDR_W-1:0] a);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic [LINE_W-1:0]  line;
        int                 way;
        idx = a[OFFSET_W +: INDEX_W];
        tag = a[ADDR_W-1 -: TAG_W];
        line = line_for({a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < SETS; s++) begin
                if (m_age[w][s] < AGE_MAX) begin
                    m_age[w][s]++;
                end
            end
        end
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                way = w;
            end
        end
        exp_miss = (way < 0);
        if (exp_miss) begin
            if (!m_valid[0][idx]) begin
                way = 0;
            end else if (!m_valid[1][idx]) begin
                way = 1;
            end else begin
                way = (m_age[1][idx] > m_age[0][idx]) ? 1 : 0;
            end
            m_tag[way][idx] = tag;
            m_valid[way][idx] = 1'b1;
        end
        m_age[way][idx] = 0;
        exp_dat = a[WSEL_BIT] ? line[LINE_W-1 -: WORD_W] : line[WORD_W-1:0];
    endtask

    // sampled mid-cycle, where every DUT output is settled
    always @(negedge clk) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[0][s] = 1'b0;
                m_valid[1][s] = 1'b0;
                m_age[0][s] = 0;
                m_age[1][s] = 0;
            end
            busy = 1'b0;
            mem_cyc_q = 1'b0;
            test_reqs = 0;
            test_errs = 0;
            o_errors = 0;
            o_requests = 0;
        end else begin
            if (i_mem_cyc != i_mem_stb) begin
                report("memory cyc and stb differ");
            end
            if (!busy) begin
                if (i_cpu_ack || i_mem_cyc) begin
                    report($sformatf("ack or memory cycle with no request pending, test %s",
                                     test_name(i_test_id)));
                end else if (i_cpu_cyc && i_cpu_stb) begin
                    busy = 1'b1;
                    req_adr = i_cpu_adr;
                    cycles = 0;
                    refills = 0;
                    predict(i_cpu_adr);
                end
            end else begin
                cycles++;
                if (i_mem_cyc && !mem_cyc_q) begin
                    refills++;
                    if (i_mem_adr != {req_adr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}) begin
                        report($sformatf("refill at wrong address %h for request %h",
                                         i_mem_adr, req_adr));
                    end
                end
                if (i_cpu_ack) begin
                    if (i_cpu_dat !== exp_dat) begin
                        report($sformatf("Mismatch %s adr %h expected %h actual %h",
                                         test_name(i_test_id), req_adr, exp_dat, i_cpu_dat));
                    end
                    if (exp_miss && refills == 0) begin
                        report($sformatf("missing refill for request %h", req_adr));
                    end else if (!exp_miss && refills != 0) begin
                        report($sformatf("unexpected refill on a hit at %h", req_adr));
                    end else if (refills > 1) begin
                        report($sformatf("more than one refill for request %h", req_adr));
                    end
                    if (!exp_miss && cycles != 2) begin
                        report($sformatf("hit at %h acknowledged after %0d cycles, not 2",
                                         req_adr, cycles));
                    end
                    busy = 1'b0;
                    test_reqs++;
                    o_requests++;
                end
            end
            mem_cyc_q = i_mem_cyc;
            if (i_test_done) begin
                $display("test %s: %0d requests, %0d errors",
                         test_name(i_test_id), test_reqs, test_errs);
                test_reqs = 0;
                test_errs = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* icache_top.sv */
//********************
// two-way instruction cache top level
// core connects to the cpu Wishbone slave port,
// memory to the 64-bit Wishbone master port
//********************
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          i_cpu_cyc,
    input  wire logic                          i_cpu_stb,
    input  wire logic [icache_pkg::ADDR_W-1:0] i_cpu_adr,
    output logic                               o_cpu_ack,
    output logic      [icache_pkg::WORD_W-1:0] o_cpu_dat,
    output logic                               o_mem_cyc,
    output logic                               o_mem_stb,
    output logic      [icache_pkg::ADDR_W-1:0] o_mem_adr,
    input  wire logic                          i_mem_ack,
    input  wire logic [icache_pkg::LINE_W-1:0] i_mem_dat
);
    import icache_pkg::*;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag_wr;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    logic               tag_we0;
    logic               tag_we1;
    logic               valid0;
    logic               valid1;
    logic               data_we0;
    logic               data_we1;
    logic [LINE_W-1:0]  line_wr;
    logic [LINE_W-1:0]  line0;
    logic [LINE_W-1:0]  line1;
    logic               access;
    logic               touch;
    logic               touch_way;
    logic               victim;

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_cpu_cyc   (i_cpu_cyc),
        .i_cpu_stb   (i_cpu_stb),
        .i_cpu_adr   (i_cpu_adr),
        .o_cpu_ack   (o_cpu_ack),
        .o_cpu_dat   (o_cpu_dat),
        .o_mem_cyc   (o_mem_cyc),
        .o_mem_stb   (o_mem_stb),
        .o_mem_adr   (o_mem_adr),
        .i_mem_ack   (i_mem_ack),
        .i_mem_dat   (i_mem_dat),
        .o_index     (index),
        .o_tag_we0   (tag_we0),
        .o_tag_we1   (tag_we1),
        .o_tag       (tag_wr),
        .i_tag0      (tag0),
        .i_tag1      (tag1),
        .i_valid0    (valid0),
        .i_valid1    (valid1),
        .o_data_we0  (data_we0),
        .o_data_we1  (data_we1),
        .o_line      (line_wr),
        .i_line0     (line0),
        .i_line1     (line1),
        .o_access    (access),
        .o_touch     (touch),
        .o_touch_way (touch_way),
        .i_victim    (victim)
    );

    icache_tag_ram u_tag0 (
        .clk(clk), .rst(rst), .i_index(index), .i_we(tag_we0),
        .i_tag(tag_wr), .o_tag(tag0), .o_valid(valid0)
    );

    icache_tag_ram u_tag1 (
        .clk(clk), .rst(rst), .i_index(index), .i_we(tag_we1),
        .i_tag(tag_wr), .o_tag(tag1), .o_valid(valid1)
    );

    icache_data_ram u_data0 (
        .clk(clk), .i_index(index), .i_we(data_we0), .i_line(line_wr), .o_line(line0)
    );

    icache_data_ram u_data1 (
        .clk(clk), .i_index(index), .i_we(data_we1), .i_line(line_wr), .o_line(line1)
    );

    icache_age u_age (
        .clk         (clk),
        .rst         (rst),
        .i_access    (access),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_index     (index),
        .i_valid0    (valid0),
        .i_valid1    (valid1),
        .o_victim    (victim)
    );

endmodule

`default_nettype wire

/* icache_ctrl.sv */
//********************
// cache controller: lookup, hit select and line refill
// core side is a Wishbone classic slave, memory side a
// Wishbone classic master fetching one 64-bit line
//********************
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    // core port
    input  wire logic                           i_cpu_cyc,
    input  wire logic                           i_cpu_stb,
    input  wire logic [icache_pkg::ADDR_W-1:0]  i_cpu_adr,
    output logic                                o_cpu_ack,
    output logic      [icache_pkg::WORD_W-1:0]  o_cpu_dat,
    // memory port
    output logic                                o_mem_cyc,
    output logic                                o_mem_stb,
    output logic      [icache_pkg::ADDR_W-1:0]  o_mem_adr,
    input  wire logic                           i_mem_ack,
    input  wire logic [icache_pkg::LINE_W-1:0]  i_mem_dat,
    // tag and data rams
    output logic      [icache_pkg::INDEX_W-1:0] o_index,
    output logic                                o_tag_we0,
    output logic                                o_tag_we1,
    output logic      [icache_pkg::TAG_W-1:0]   o_tag,
    input  wire logic [icache_pkg::TAG_W-1:0]   i_tag0,
    input  wire logic [icache_pkg::TAG_W-1:0]   i_tag1,
    input  wire logic                           i_valid0,
    input  wire logic                           i_valid1,
    output logic                                o_data_we0,
    output logic                                o_data_we1,
    output logic      [icache_pkg::LINE_W-1:0]  o_line,
    input  wire logic [icache_pkg::LINE_W-1:0]  i_line0,
    input  wire logic [icache_pkg::LINE_W-1:0]  i_line1,
    // age block
    output logic                                o_access,
    output logic                                o_touch,
    output logic                                o_touch_way,
    input  wire logic                           i_victim
);
    import icache_pkg::*;

    ctrl_state_t       state;
    ctrl_state_t       state_nxt;
    logic [TAG_W-1:0]  req_tag;
    logic              wsel;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              victim_q;
    logic [LINE_W-1:0] line_q;
    logic [WORD_W-1:0] dat_q;

    // address is held by the core until ack, no local copy
    assign req_tag = i_cpu_adr[ADDR_W-1 -: TAG_W];
    assign o_index = i_cpu_adr[OFFSET_W +: INDEX_W];
    assign wsel    = i_cpu_adr[WSEL_BIT];

    assign hit0 = i_valid0 && (i_tag0 == req_tag);
    assign hit1 = i_valid1 && (i_tag1 == req_tag);
    assign hit  = hit0 || hit1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_cpu_cyc && i_cpu_stb) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = hit ? RESPOND : REFILL;
            end
            REFILL: begin
                if (i_mem_ack) begin
                    state_nxt = FILL;
                end
            end
            FILL:    state_nxt = RESPOND;
            RESPOND: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // victim is fixed once the miss is known
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            victim_q <= 1'b0;
        end else if (state == LOOKUP && !hit) begin
            victim_q <= i_victim;
        end
    end

    always_ff @(posedge clk) begin
        if (state == REFILL && i_mem_ack) begin
            line_q <= i_mem_dat;
        end
        if (state == LOOKUP) begin
            if (hit1) begin
                dat_q <= wsel ? i_line1[LINE_W-1 -: WORD_W] : i_line1[WORD_W-1:0];
            end else begin
                dat_q <= wsel ? i_line0[LINE_W-1 -: WORD_W] : i_line0[WORD_W-1:0];
            end
        end else if (state == FILL) begin
            dat_q <= wsel ? line_q[LINE_W-1 -: WORD_W] : line_q[WORD_W-1:0];
        end
    end

    assign o_cpu_ack = (state == RESPOND);
    assign o_cpu_dat = dat_q;

    // line address, offset bits forced to zero
    assign o_mem_cyc = (state == REFILL);
    assign o_mem_stb = (state == REFILL);
    assign o_mem_adr = {i_cpu_adr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign o_tag      = req_tag;
    assign o_line     = line_q;
    assign o_tag_we0  = (state == FILL) && !victim_q;
    assign o_tag_we1  = (state == FILL) && victim_q;
    assign o_data_we0 = o_tag_we0;
    assign o_data_we1 = o_tag_we1;

    assign o_access    = (state == IDLE) && i_cpu_cyc && i_cpu_stb;
    assign o_touch     = ((state == LOOKUP) && hit) || (state == FILL);
    assign o_touch_way = (state == FILL) ? victim_q : hit1;

    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (!rst) o_mem_stb |-> o_mem_cyc
    );

    a_no_ack_in_refill: assert property (
        @(posedge clk) disable iff (!rst) !(o_cpu_ack && o_mem_cyc)
    );

    // a line must never sit in both ways
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst) (state == LOOKUP) |-> !(hit0 && hit1)
    );

endmodule

`default_nettype wire

/* icache_age.sv */
//********************
// per-set age counters for both ways
// every accepted request ages all sets, a hit or fill
// clears the touched way; victim picked from the oldest
//********************
`timescale 1ns/1ps
`default_nettype none

module icache_age (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           i_access,
    input  wire logic                           i_touch,
    input  wire logic                           i_touch_way,
    input  wire logic [icache_pkg::INDEX_W-1:0] i_index,
    input  wire logic                           i_valid0,
    input  wire logic                           i_valid1,
    output logic                                o_victim
);
    import icache_pkg::*;

    logic [AGE_W-1:0] age0 [SETS];
    logic [AGE_W-1:0] age1 [SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else begin
            if (i_access) begin
                for (int s = 0; s < SETS; s++) begin
                    if (age0[s] != AGE_W'(AGE_MAX)) begin
                        age0[s] <= age0[s] + AGE_W'(1);
                    end
                    if (age1[s] != AGE_W'(AGE_MAX)) begin
                        age1[s] <= age1[s] + AGE_W'(1);
                    end
                end
            end
            // clear wins over the increment in the same set
            if (i_touch && !i_touch_way) begin
                age0[i_index] <= '0;
            end
            if (i_touch && i_touch_way) begin
                age1[i_index] <= '0;
            end
        end
    end

    // empty way first, else oldest, tie goes to way 0
    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = (age1[i_index] > age0[i_index]);
        end
    end

    a_no_touch_on_access: assert property (
        @(posedge clk) disable iff (!rst) !(i_touch && i_access)
    );

endmodule

`default_nettype wire

/* icache_data_ram.sv */
//********************
// line store for one way, 64 x 64 bit
// registered read, written once per refill
//********************
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram (
    input  wire logic                           clk,
    input  wire logic [icache_pkg::INDEX_W-1:0] i_index,
    input  wire logic                           i_we,
    input  wire logic [icache_pkg::LINE_W-1:0]  i_line,
    output logic      [icache_pkg::LINE_W-1:0]  o_line
);
    import icache_pkg::*;

    logic [LINE_W-1:0] lines [SETS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            lines[i_index] <= i_line;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        o_line <= lines[i_index];
    end

endmodule

`default_nettype wire

/* icache_tag_ram.sv */
//********************
// tag store for one way, 64 entries
// registered read, valid bits cleared only by reset
//********************
`timescale 1ns/1ps
`default_nettype none

module icache_tag_ram (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [icache_pkg::INDEX_W-1:0] i_index,
    input  wire logic                          i_we,
    input  wire logic [icache_pkg::TAG_W-1:0]   i_tag,
    output logic      [icache_pkg::TAG_W-1:0]   o_tag,
    output logic                               o_valid
);
    import icache_pkg::*;

    logic [TAG_W-1:0] tags [SETS];
    logic [SETS-1:0]  valid;

    // tag array has no reset
    always_ff @(posedge clk) begin
        if (i_we) begin
            tags[i_index] <= i_tag;
        end
        o_tag <= tags[i_index];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid   <= '0;
            o_valid <= 1'b0;
        end else begin
            if (i_we) begin
                valid[i_index] <= 1'b1;
            end
            // old value on a write cycle, new one on the next read
            o_valid <= valid[i_index];
        end
    end

endmodule

`default_nettype wire

/* icache_pkg.sv */
//********************
// shared definitions for the two-way instruction cache:
// address split, line geometry, age counter width and
// the controller state encoding
//********************
`default_nettype none

package icache_pkg;

    // byte address as seen by the core
    localparam int ADDR_W   = 32;

    // 8-byte line, bit 2 picks the instruction inside it
    localparam int OFFSET_W = 3;
    localparam int WSEL_BIT = 2;

    // 64 sets, index taken from bits 8..3
    localparam int INDEX_W  = 6;
    localparam int SETS     = 64;

    // remaining upper bits, 31..9
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // two instructions per line
    localparam int LINE_W   = 64;
    localparam int WORD_W   = 32;

    // saturating age counters used for replacement
    localparam int AGE_W    = 3;
    localparam int AGE_MAX  = 7;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        // tags and lines are valid out of the rams here
        LOOKUP  = 3'd1,
        // Wishbone read cycle to memory in progress
        REFILL  = 3'd2,
        // write victim way, build the response word
        FILL    = 3'd3,
        RESPOND = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire
